// ==== verilog/veriyolu_consts.svh ====
// Address-select field position and peripheral region codes.
`ifndef VERIYOLU_CONSTS_SVH
`define VERIYOLU_CONSTS_SVH

// Region code lives in these address bits.
`define VY_SEL_MSB 13
`define VY_SEL_LSB 12

// UART at 0x0000_0xxx.
`define VY_REGION_UART 2'd0
// SPI at 0x0000_1xxx.
`define VY_REGION_SPI  2'd1
// PWM at 0x0000_2xxx.
`define VY_REGION_PWM  2'd2
// Unmapped, completes without a bus cycle.
`define VY_REGION_NONE 2'd3

`endif

// ==== verilog/veriyolu_pkg.sv ====
// Word, address and region types with the master and slave FSM state enums.
`include "veriyolu_consts.svh"

package veriyolu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [`VY_SEL_MSB-`VY_SEL_LSB:0] region_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_BUS,     // Waiting for slave ack.
        MS_RESP     // Unmapped access, one busy cycle.
    } master_state_t;

    typedef enum logic [1:0] {
        SS_IDLE,
        SS_WAIT_READY,  // Device busy.
        SS_WAIT_DATA,   // Read strobe sent.
        SS_ACK          // Write strobe sent.
    } slave_state_t;

endpackage

// ==== verilog/wb_if.sv ====
// Wishbone point-to-point interface with master and slave modports.
interface wb_if
    import veriyolu_pkg::*;
();

    addr_t adr;
    word_t dat_w;
    logic  we;
    logic  cyc;
    logic  stb;
    word_t dat_r;
    logic  ack;   // Single-cycle pulse.

    modport master (
        output adr, dat_w, we, cyc, stb,
        input  dat_r, ack
    );

    modport slave (
        input  adr, dat_w, we, cyc, stb,
        output dat_r, ack
    );

endinterface

// ==== verilog/wishbone_master.sv ====
// Wishbone master with command port, region decode, cycle control and response capture.
`include "veriyolu_consts.svh"

module wishbone_master
    import veriyolu_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  addr_t cmd_addr_i,
    input  word_t cmd_wdata_i,
    input  logic  cmd_we_i,
    input  logic  cmd_sel_i,
    output logic  cmd_busy_o,
    output word_t cmd_rdata_o,
    output logic  cmd_rdata_valid_o,
    wb_if.master  uart_bus,
    wb_if.master  spi_bus,
    wb_if.master  pwm_bus
);

    master_state_t state_q;
    addr_t         addr_q;
    word_t         wdata_q;
    logic          we_q;
    region_t       region_q;
    region_t       cmd_region;
    logic          cmd_take;
    logic          in_bus;
    logic          resp_done;
    logic          ack_sel;
    word_t         rdata_sel;

    assign cmd_region = cmd_addr_i[`VY_SEL_MSB:`VY_SEL_LSB];
    assign cmd_busy_o = (state_q != MS_IDLE);
    assign cmd_take   = cmd_sel_i && !cmd_busy_o;
    assign in_bus     = (state_q == MS_BUS);
    assign resp_done  = (in_bus && ack_sel) || (state_q == MS_RESP);

    assign uart_bus.adr   = addr_q;
    assign uart_bus.dat_w = wdata_q;
    assign uart_bus.we    = we_q;
    assign uart_bus.cyc   = in_bus && (region_q == `VY_REGION_UART);
    assign uart_bus.stb   = in_bus && (region_q == `VY_REGION_UART);

    assign spi_bus.adr    = addr_q;
    assign spi_bus.dat_w  = wdata_q;
    assign spi_bus.we     = we_q;
    assign spi_bus.cyc    = in_bus && (region_q == `VY_REGION_SPI);
    assign spi_bus.stb    = in_bus && (region_q == `VY_REGION_SPI);

    assign pwm_bus.adr    = addr_q;
    assign pwm_bus.dat_w  = wdata_q;
    assign pwm_bus.we     = we_q;
    assign pwm_bus.cyc    = in_bus && (region_q == `VY_REGION_PWM);
    assign pwm_bus.stb    = in_bus && (region_q == `VY_REGION_PWM);

    always_comb begin
        ack_sel   = 1'b0;
        rdata_sel = '0;  // Unmapped reads return zero.
        case (region_q)
            `VY_REGION_UART: begin
                ack_sel   = uart_bus.ack;
                rdata_sel = uart_bus.dat_r;
            end
            `VY_REGION_SPI: begin
                ack_sel   = spi_bus.ack;
                rdata_sel = spi_bus.dat_r;
            end
            `VY_REGION_PWM: begin
                ack_sel   = pwm_bus.ack;
                rdata_sel = pwm_bus.dat_r;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q           <= MS_IDLE;
            cmd_rdata_valid_o <= 1'b0;
        end else begin
            cmd_rdata_valid_o <= resp_done && !we_q;
            case (state_q)
                MS_IDLE: begin
                    if (cmd_take) begin
                        state_q <= (cmd_region == `VY_REGION_NONE) ? MS_RESP : MS_BUS;
                    end
                end
                MS_BUS: begin
                    if (ack_sel) begin
                        state_q <= MS_IDLE;
                    end
                end
                default: state_q <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_take) begin
            addr_q   <= cmd_addr_i;
            wdata_q  <= cmd_wdata_i;
            we_q     <= cmd_we_i;
            region_q <= cmd_region;
        end
        if (resp_done && !we_q) begin
            cmd_rdata_o <= rdata_sel;  // Held until the next read.
        end
    end

endmodule

// ==== verilog/wishbone_slave.sv ====
// Wishbone slave that bridges one bus cycle to one device strobe.
module wishbone_slave
    import veriyolu_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    wb_if.slave   bus,
    input  logic  device_busy_i,
    input  word_t device_rdata_i,
    input  logic  device_rdata_valid_i,
    output addr_t device_addr_o,
    output word_t device_wdata_o,
    output logic  device_en_o,
    output logic  device_we_o
);

    slave_state_t state_q;
    logic         ack_q;
    word_t        rdata_q;
    logic         start;
    logic         read_done;

    // Ack is still high in the first idle cycle, so cyc is ignored there.
    assign start     = (state_q == SS_IDLE) && bus.cyc && bus.stb && !ack_q;
    assign read_done = (state_q == SS_WAIT_DATA) && device_rdata_valid_i;

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdata_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= SS_IDLE;
            ack_q       <= 1'b0;
            device_en_o <= 1'b0;
            device_we_o <= 1'b0;
        end else begin
            ack_q       <= 1'b0;
            device_en_o <= 1'b0;
            device_we_o <= 1'b0;
            case (state_q)
                SS_IDLE: begin
                    if (start) begin
                        state_q <= SS_WAIT_READY;
                    end
                end
                SS_WAIT_READY: begin
                    if (!device_busy_i) begin
                        device_en_o <= 1'b1;
                        device_we_o <= bus.we;
                        state_q     <= bus.we ? SS_ACK : SS_WAIT_DATA;
                    end
                end
                SS_WAIT_DATA: begin
                    if (device_rdata_valid_i) begin
                        ack_q   <= 1'b1;
                        state_q <= SS_IDLE;
                    end
                end
                SS_ACK: begin
                    ack_q   <= 1'b1;  // Write strobe went out last cycle.
                    state_q <= SS_IDLE;
                end
                default: state_q <= SS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            device_addr_o  <= bus.adr;
            device_wdata_o <= bus.dat_w;
        end
        if (read_done) begin
            rdata_q <= device_rdata_i;
        end
    end

endmodule

// ==== verilog/veriyolu.sv ====
// Peripheral bus top level with one Wishbone master and UART, SPI and PWM slaves.
module veriyolu
    import veriyolu_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,

    input  addr_t vyd_wb_adres_i,
    input  word_t vyd_wb_veri_i,
    input  logic  vyd_wb_yaz_etkin_i,
    input  logic  vyd_wb_sec_i,
    output word_t wb_vyd_veri_o,
    output logic  wb_vyd_veri_hazir_o,
    output logic  wb_vyd_mesgul_o,

    input  logic  uart_wb_mesgul_i,
    input  word_t uart_wb_oku_veri_i,
    input  logic  uart_wb_oku_veri_hazir_i,
    output addr_t wb_uart_adres_o,
    output word_t wb_uart_veri_o,
    output logic  wb_uart_etkin_o,
    output logic  wb_uart_yaz_etkin_o,

    input  logic  spi_wb_mesgul_i,
    input  word_t spi_wb_oku_veri_i,
    input  logic  spi_wb_oku_veri_hazir_i,
    output addr_t wb_spi_adres_o,
    output word_t wb_spi_veri_o,
    output logic  wb_spi_etkin_o,
    output logic  wb_spi_yaz_etkin_o,

    input  logic  pwm_wb_mesgul_i,
    input  word_t pwm_wb_oku_veri_i,
    input  logic  pwm_wb_oku_veri_hazir_i,
    output addr_t wb_pwm_adres_o,
    output word_t wb_pwm_veri_o,
    output logic  wb_pwm_etkin_o,
    output logic  wb_pwm_yaz_etkin_o
);

    wb_if uart_bus ();
    wb_if spi_bus ();
    wb_if pwm_bus ();

    wishbone_master wm (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .cmd_addr_i        (vyd_wb_adres_i),
        .cmd_wdata_i       (vyd_wb_veri_i),
        .cmd_we_i          (vyd_wb_yaz_etkin_i),
        .cmd_sel_i         (vyd_wb_sec_i),
        .cmd_busy_o        (wb_vyd_mesgul_o),
        .cmd_rdata_o       (wb_vyd_veri_o),
        .cmd_rdata_valid_o (wb_vyd_veri_hazir_o),
        .uart_bus          (uart_bus),
        .spi_bus           (spi_bus),
        .pwm_bus           (pwm_bus)
    );

    wishbone_slave ws_uart (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .bus                  (uart_bus),
        .device_busy_i        (uart_wb_mesgul_i),
        .device_rdata_i       (uart_wb_oku_veri_i),
        .device_rdata_valid_i (uart_wb_oku_veri_hazir_i),
        .device_addr_o        (wb_uart_adres_o),
        .device_wdata_o       (wb_uart_veri_o),
        .device_en_o          (wb_uart_etkin_o),
        .device_we_o          (wb_uart_yaz_etkin_o)
    );

    wishbone_slave ws_spi (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .bus                  (spi_bus),
        .device_busy_i        (spi_wb_mesgul_i),
        .device_rdata_i       (spi_wb_oku_veri_i),
        .device_rdata_valid_i (spi_wb_oku_veri_hazir_i),
        .device_addr_o        (wb_spi_adres_o),
        .device_wdata_o       (wb_spi_veri_o),
        .device_en_o          (wb_spi_etkin_o),
        .device_we_o          (wb_spi_yaz_etkin_o)
    );

    wishbone_slave ws_pwm (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .bus                  (pwm_bus),
        .device_busy_i        (pwm_wb_mesgul_i),
        .device_rdata_i       (pwm_wb_oku_veri_i),
        .device_rdata_valid_i (pwm_wb_oku_veri_hazir_i),
        .device_addr_o        (wb_pwm_adres_o),
        .device_wdata_o       (wb_pwm_veri_o),
        .device_en_o          (wb_pwm_etkin_o),
        .device_we_o          (wb_pwm_yaz_etkin_o)
    );

endmodule

// ==== sim/tb_veriyolu.sv ====
// Testbench with clock, reset, trace replay, UART, SPI and PWM models and bus checks.
`include "veriyolu_consts.svh"

module tb_veriyolu
    import veriyolu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;  // Cycles per command.

    logic  clk;
    logic  reset = 1'b1;
    addr_t cmd_addr = '0;
    word_t cmd_wdata = '0;
    logic  cmd_we = 1'b0;
    logic  cmd_sel = 1'b0;
    word_t rdata;
    logic  rdata_valid;
    logic  busy;
    logic  cmd_take;

    // Index 0 is UART, 1 is SPI, 2 is PWM.
    logic [2:0]        dev_en;
    logic [2:0]        dev_we;
    logic [2:0]        dev_busy = '0;
    logic [2:0]        dev_valid = '0;
    addr_t [2:0]       dev_addr;
    word_t [2:0]       dev_wdata;
    word_t [2:0]       dev_rdata = '0;
    word_t             dev_mem [3][16];
    int                busy_cnt [3] = '{default: 0};
    int                read_cnt [3] = '{default: 0};
    string             dev_name [3] = '{"uart", "spi", "pwm"};
    integer            seed = 27;

    addr_t      cur_addr;
    word_t      cur_wdata;
    logic       cur_we;
    region_t    cur_region;
    logic       wait_strobe;
    logic [2:0] busy_prev;
    int         strobe_cnt;
    int         valid_cnt;
    int         bus_errors = 0;
    int         cmd_errors = 0;
    int         commands = 0;

    veriyolu dut (
        .clk_i                    (clk),
        .reset_i                  (reset),
        .vyd_wb_adres_i           (cmd_addr),
        .vyd_wb_veri_i            (cmd_wdata),
        .vyd_wb_yaz_etkin_i       (cmd_we),
        .vyd_wb_sec_i             (cmd_sel),
        .wb_vyd_veri_o            (rdata),
        .wb_vyd_veri_hazir_o      (rdata_valid),
        .wb_vyd_mesgul_o          (busy),
        .uart_wb_mesgul_i         (dev_busy[0]),
        .uart_wb_oku_veri_i       (dev_rdata[0]),
        .uart_wb_oku_veri_hazir_i (dev_valid[0]),
        .wb_uart_adres_o          (dev_addr[0]),
        .wb_uart_veri_o           (dev_wdata[0]),
        .wb_uart_etkin_o          (dev_en[0]),
        .wb_uart_yaz_etkin_o      (dev_we[0]),
        .spi_wb_mesgul_i          (dev_busy[1]),
        .spi_wb_oku_veri_i        (dev_rdata[1]),
        .spi_wb_oku_veri_hazir_i  (dev_valid[1]),
        .wb_spi_adres_o           (dev_addr[1]),
        .wb_spi_veri_o            (dev_wdata[1]),
        .wb_spi_etkin_o           (dev_en[1]),
        .wb_spi_yaz_etkin_o       (dev_we[1]),
        .pwm_wb_mesgul_i          (dev_busy[2]),
        .pwm_wb_oku_veri_i        (dev_rdata[2]),
        .pwm_wb_oku_veri_hazir_i  (dev_valid[2]),
        .wb_pwm_adres_o           (dev_addr[2]),
        .wb_pwm_veri_o            (dev_wdata[2]),
        .wb_pwm_etkin_o           (dev_en[2]),
        .wb_pwm_yaz_etkin_o       (dev_we[2])
    );

    assign cmd_take = cmd_sel && !busy;

    task automatic note_error(inout int count, input string msg);
        count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic log_mismatch(inout int count, input string name, input word_t got,
                                input word_t expected);
        count++;
        $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic check_strobe();
        int idx;
        idx = int'(cur_region);
        assert (dev_en == (3'b001 << cur_region))
            else note_error(bus_errors, "etkin pulsed on a peripheral the address does not select");
        if (idx < 3) begin
            assert (dev_addr[idx] == cur_addr)
                else log_mismatch(bus_errors, {"wb_", dev_name[idx], "_adres_o"},
                                  dev_addr[idx], cur_addr);
            assert (dev_we[idx] == cur_we)
                else log_mismatch(bus_errors, {"wb_", dev_name[idx], "_yaz_etkin_o"},
                                  dev_we[idx], cur_we);
            if (cur_we) begin
                assert (dev_wdata[idx] == cur_wdata)
                    else log_mismatch(bus_errors, {"wb_", dev_name[idx], "_veri_o"},
                                      dev_wdata[idx], cur_wdata);
            end
        end
    endtask

    // Register arrays with random busy time and read latency.
    always @(posedge clk) begin
        for (int p = 0; p < 3; p++) begin
            dev_valid[p] <= 1'b0;
            if (reset) begin
                for (int i = 0; i < 16; i++) begin
                    dev_mem[p][i] = 32'h5a00_0000 | (p << 8) | i;
                end
                busy_cnt[p] = 0;
                read_cnt[p] = 0;
            end else begin
                if (cmd_take) begin
                    busy_cnt[p] = {$random(seed)} % 4;  // Stall for 0 to 3 cycles.
                end else if (busy_cnt[p] != 0) begin
                    busy_cnt[p] = busy_cnt[p] - 1;
                end
                if (dev_en[p] && dev_we[p]) begin
                    dev_mem[p][dev_addr[p][5:2]] = dev_wdata[p];
                end
                if (dev_en[p] && !dev_we[p]) begin
                    read_cnt[p] = 1 + {$random(seed)} % 3;
                end else if (read_cnt[p] != 0) begin
                    read_cnt[p] = read_cnt[p] - 1;
                    if (read_cnt[p] == 0) begin
                        dev_valid[p] <= 1'b1;
                        dev_rdata[p] <= dev_mem[p][dev_addr[p][5:2]];
                    end
                end
            end
            dev_busy[p] <= (busy_cnt[p] != 0);
        end
    end

    // Bus monitor for the command in flight.
    always @(posedge clk) begin
        busy_prev <= dev_busy;
        if (reset) begin
            wait_strobe <= 1'b0;
            strobe_cnt  <= 0;
            valid_cnt   <= 0;
        end else if (cmd_take) begin
            cur_addr    <= cmd_addr;
            cur_wdata   <= cmd_wdata;
            cur_we      <= cmd_we;
            cur_region  <= cmd_addr[`VY_SEL_MSB:`VY_SEL_LSB];
            wait_strobe <= (cmd_addr[`VY_SEL_MSB:`VY_SEL_LSB] != `VY_REGION_NONE);
            strobe_cnt  <= 0;
            valid_cnt   <= 0;
        end else begin
            if (rdata_valid) begin
                valid_cnt <= valid_cnt + 1;
            end
            if (dev_en != 3'b000) begin
                strobe_cnt  <= strobe_cnt + 1;
                wait_strobe <= 1'b0;
                check_strobe();
            end
            assert ((dev_en & busy_prev) == 3'b000)
                else note_error(bus_errors, "strobe reached a peripheral that was busy");
            assert ((dev_we & ~dev_en) == 3'b000)
                else note_error(bus_errors, "yaz_etkin high without etkin");
            if (wait_strobe && dev_busy[cur_region]) begin
                assert (busy) else note_error(bus_errors, "wb_vyd_mesgul_o low during a stall");
            end
        end
    end

    task automatic run_command(input logic we, input addr_t addr, input word_t wdata,
                               input word_t expected, output logic timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        cmd_addr  <= addr;
        cmd_wdata <= wdata;
        cmd_we    <= we;
        cmd_sel   <= 1'b1;
        @(posedge clk);
        cmd_sel <= 1'b0;
        @(posedge clk);
        while (busy && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (busy) begin
            timed_out = 1'b1;
            note_error(cmd_errors, $sformatf("command to %h never finished", addr));
        end else begin
            if (!we) begin
                assert (rdata_valid)
                    else log_mismatch(cmd_errors, "wb_vyd_veri_hazir_o", rdata_valid, 1'b1);
                assert (rdata == expected)
                    else log_mismatch(cmd_errors, "wb_vyd_veri_o", rdata, expected);
            end
            @(posedge clk);
            // Valid is a single-cycle pulse.
            assert (!rdata_valid)
                else log_mismatch(cmd_errors, "wb_vyd_veri_hazir_o", rdata_valid, 1'b0);
            assert (strobe_cnt == ((addr[`VY_SEL_MSB:`VY_SEL_LSB] == `VY_REGION_NONE) ? 0 : 1))
                else note_error(cmd_errors, $sformatf("%0d strobes for one command", strobe_cnt));
            assert (valid_cnt == (we ? 0 : 1))
                else note_error(cmd_errors, $sformatf("%0d veri_hazir pulses", valid_cnt));
            commands++;
        end
    endtask

    task automatic expect_idle();
        assert (!busy && !rdata_valid)
            else note_error(cmd_errors, "mesgul or veri_hazir high after reset");
        assert (dev_en == 3'b000 && dev_we == 3'b000)
            else note_error(cmd_errors, "peripheral strobe high after reset");
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [7:0]       op;
        addr_t            addr;
        word_t            wdata;
        word_t            expected;
        logic             timed_out;
        timed_out = 1'b0;
        fd = $fopen("sim/veriyolu_trace.txt", "r");
        if (fd == 0) begin
            note_error(cmd_errors, "cannot open sim/veriyolu_trace.txt");
        end else begin
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            @(posedge clk);
            expect_idle();
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                n = $fgets(line, fd);
                // Comment and blank lines do not parse to four fields.
                if (n > 0 && $sscanf(line, "%s %h %h %h", op, addr, wdata, expected) == 4) begin
                    run_command(op == "W", addr, wdata, expected, timed_out);
                end
            end
            $fclose(fd);
            if (commands == 0) begin
                note_error(cmd_errors, "trace file held no commands");
            end
        end
        $display("Commands %0d, bus errors %0d, command errors %0d",
                 commands, bus_errors, cmd_errors);
        if (bus_errors == 0 && cmd_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim/veriyolu_trace.txt ====
# op  address   write_data  expected_read
# R compares the returned word with the last column, W leaves it unused
W 00000000 11111111 00000000
R 00000000 00000000 11111111
W 00001000 22222222 00000000
R 00001000 00000000 22222222
W 00002000 33333333 00000000
R 00002000 00000000 33333333
W 00000004 a5a5a5a5 00000000
W 00001008 cafe0001 00000000
W 0000200c 0badf00d 00000000
R 00000004 00000000 a5a5a5a5
R 00001008 00000000 cafe0001
R 0000200c 00000000 0badf00d
W 00003000 deadbeef 00000000
R 00003000 00000000 00000000
W 0000003c 3c3c3c3c 00000000
R 0000003c 00000000 3c3c3c3c
W 00001ffc 87654321 00000000
R 00001ffc 00000000 87654321
W 00002ff0 00000fff 00000000
R 00002ff0 00000000 00000fff
W 00000000 fedcba98 00000000
R 00000000 00000000 fedcba98
R 00003ffc 00000000 00000000
R 00001000 00000000 22222222

// ==== verilog.f ====
+incdir+verilog
verilog/veriyolu_pkg.sv
verilog/wb_if.sv
verilog/wishbone_master.sv
verilog/wishbone_slave.sv
verilog/veriyolu.sv
sim/tb_veriyolu.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_veriyolu
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(SIM_LOG)
	grep -qx "$(PASS_MSG)" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
